//--- rtl/spi_slave_pkg.sv
package spi_slave_pkg;

  // --------------------------------------------------------------------------
  // sizes
  // --------------------------------------------------------------------------

  // register and spi byte width
  localparam int DATA_W    = 8;
  // register bank addressing
  localparam int ADDR_W    = 4;
  localparam int REG_COUNT = 16;
  // mosi and miso lane count
  localparam int LANES     = 4;
  // receive counter width, counts bits or nibbles within a byte
  localparam int BIT_CNT_W = 3;

  // --------------------------------------------------------------------------
  // types
  // --------------------------------------------------------------------------

  // static mode level, may change only while cs_n is high
  typedef struct packed {
    logic cpol;
    logic cpha;
  } spi_mode_t;

  typedef enum logic [7:0] {
    OP_WRITE = 8'h02,
    OP_READ  = 8'h03,
    OP_QREAD = 8'h6b
  } spi_op_e;

  // synchronized events, all in the sclk domain
  typedef struct packed {
    logic             sample;
    logic             shift;
    logic             frame_start;
    logic             frame_end;
    logic             active;
    logic [LANES-1:0] sdi;
  } spi_edges_t;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic              load;
    logic              quad;
    logic [DATA_W-1:0] data;
  } tx_cmd_t;

endpackage

//--- rtl/spi_edge_sync.sv
module spi_edge_sync (
  input  logic                      sclk,
  input  logic                      arst_n,
  input  spi_slave_pkg::spi_mode_t  mode,
  input  logic                      spi_clk,
  input  logic                      cs_n,
  input  logic [spi_slave_pkg::LANES-1:0] mosi,
  output spi_slave_pkg::spi_edges_t edges
);

  logic clk_meta;
  logic clk_sync;
  logic clk_dly;
  logic cs_meta;
  logic cs_sync;
  logic cs_dly;
  logic [spi_slave_pkg::LANES-1:0] mosi_meta;
  logic [spi_slave_pkg::LANES-1:0] mosi_sync;

  logic clk_toggle;
  logic lead_edge;
  logic trail_edge;
  logic selected;
  spi_slave_pkg::spi_edges_t edges_next;

  // --------------------------------------------------------------------------
  // two-flop synchronizers plus one delay stage for edge detection
  // --------------------------------------------------------------------------

  // select idles high, so no false frame_start out of reset
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      clk_meta <= 1'b0;
      clk_sync <= 1'b0;
      clk_dly  <= 1'b0;
      cs_meta  <= 1'b1;
      cs_sync  <= 1'b1;
      cs_dly   <= 1'b1;
    end else begin
      clk_meta <= spi_clk;
      clk_sync <= clk_meta;
      clk_dly  <= clk_sync;
      cs_meta  <= cs_n;
      cs_sync  <= cs_meta;
      cs_dly   <= cs_sync;
    end
  end

  always_ff @(posedge sclk) begin
    mosi_meta <= mosi;
    mosi_sync <= mosi_meta;
  end

  // --------------------------------------------------------------------------
  // edge classification
  // --------------------------------------------------------------------------

  // leading edge moves spi_clk away from its idle level (cpol)
  assign clk_toggle = clk_sync ^ clk_dly;
  assign lead_edge  = clk_toggle && (clk_sync != mode.cpol);
  assign trail_edge = clk_toggle && (clk_sync == mode.cpol);
  assign selected   = !cs_sync;

  always_comb begin
    edges_next.sample      = selected && (mode.cpha ? trail_edge : lead_edge);
    edges_next.shift       = selected && (mode.cpha ? lead_edge : trail_edge);
    edges_next.frame_start = cs_dly && !cs_sync;
    edges_next.frame_end   = !cs_dly && cs_sync;
    edges_next.active      = selected;
    edges_next.sdi         = mosi_sync;
  end

  // strobes land on the third sclk edge after the pin changes
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      edges <= '0;
    end else begin
      edges <= edges_next;
    end
  end

endmodule

//--- rtl/spi_shift_reg.sv
module spi_shift_reg (
  input  logic                             sclk,
  input  logic                             arst_n,
  input  logic                             quad_mode,
  input  spi_slave_pkg::spi_edges_t        edges,
  input  spi_slave_pkg::tx_cmd_t           tx_cmd,
  output logic                             rx_valid,
  output logic [spi_slave_pkg::DATA_W-1:0] rx_byte,
  output logic [spi_slave_pkg::LANES-1:0]  miso,
  output logic [spi_slave_pkg::LANES-1:0]  miso_oe
);

  localparam int DW = spi_slave_pkg::DATA_W;
  localparam int LW = spi_slave_pkg::LANES;

  logic [DW-1:0] rx_sh;
  logic [DW-1:0] rx_next;
  logic [spi_slave_pkg::BIT_CNT_W-1:0] rx_cnt;
  logic rx_last;

  logic [DW-1:0] tx_sh;
  logic tx_quad;
  logic tx_en;
  logic primed;

  // --------------------------------------------------------------------------
  // receive side
  // --------------------------------------------------------------------------

  // quad mode takes a whole nibble per sample strobe
  assign rx_next = quad_mode ? {rx_sh[DW-LW-1:0], edges.sdi} : {rx_sh[DW-2:0], edges.sdi[0]};
  assign rx_last = quad_mode ? (rx_cnt == spi_slave_pkg::BIT_CNT_W'(DW / LW - 1))
                             : (rx_cnt == spi_slave_pkg::BIT_CNT_W'(DW - 1));

  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      rx_cnt   <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= edges.sample && rx_last;
      // a partial byte is dropped at either frame boundary
      if (edges.frame_start || edges.frame_end) begin
        rx_cnt <= '0;
      end else if (edges.sample) begin
        rx_cnt <= rx_last ? '0 : rx_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge sclk) begin
    if (edges.sample) begin
      rx_sh <= rx_next;
      if (rx_last) begin
        rx_byte <= rx_next;
      end
    end
  end

  // --------------------------------------------------------------------------
  // transmit side
  // --------------------------------------------------------------------------

  // the shift strobe right after a load launches the bit already shown
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      tx_en   <= 1'b0;
      tx_quad <= 1'b0;
      primed  <= 1'b0;
    end else if (edges.frame_end) begin
      tx_en  <= 1'b0;
      primed <= 1'b0;
    end else if (tx_cmd.load) begin
      tx_en   <= 1'b1;
      tx_quad <= tx_cmd.quad;
      primed  <= 1'b1;
    end else if (edges.shift && tx_en) begin
      primed <= 1'b0;
    end
  end

  always_ff @(posedge sclk) begin
    if (tx_cmd.load) begin
      tx_sh <= tx_cmd.data;
    end else if (edges.shift && tx_en && !primed) begin
      tx_sh <= tx_quad ? {tx_sh[DW-LW-1:0], {LW{1'b0}}} : {tx_sh[DW-2:0], 1'b0};
    end
  end

  // lane 0 only in single mode, top nibble on all lanes in quad mode
  always_comb begin
    miso    = '0;
    miso_oe = '0;
    if (tx_en) begin
      if (tx_quad) begin
        miso    = tx_sh[DW-1:DW-LW];
        miso_oe = '1;
      end else begin
        miso[0]    = tx_sh[DW-1];
        miso_oe[0] = 1'b1;
      end
    end
  end

endmodule

//--- rtl/spi_slave_ctrl.sv
module spi_slave_ctrl (
  input  logic                             sclk,
  input  logic                             arst_n,
  input  spi_slave_pkg::spi_edges_t        edges,
  input  logic                             rx_valid,
  input  logic [spi_slave_pkg::DATA_W-1:0] rx_byte,
  input  logic [spi_slave_pkg::DATA_W-1:0] rdata,
  output spi_slave_pkg::tx_cmd_t           tx_cmd,
  output spi_slave_pkg::reg_req_t          reg_req,
  output logic                             quad_mode
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_ADDR,
    ST_WRITE_DATA,
    ST_READ_DATA,
    ST_DISCARD
  } state_e;

  state_e state;
  spi_slave_pkg::spi_op_e op;
  logic [spi_slave_pkg::ADDR_W-1:0] addr;
  logic load;

  // --------------------------------------------------------------------------
  // frame FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ST_IDLE;
      op        <= spi_slave_pkg::OP_WRITE;
      addr      <= '0;
      load      <= 1'b0;
      quad_mode <= 1'b0;
    end else begin
      load <= 1'b0;
      if (edges.frame_end) begin
        // cs_n high ends any frame, wherever it is
        state     <= ST_IDLE;
        quad_mode <= 1'b0;
      end else begin
        case (state)
          ST_IDLE: begin
            if (edges.active) begin
              state <= ST_CMD;
            end
          end
          ST_CMD: begin
            if (rx_valid) begin
              case (rx_byte)
                spi_slave_pkg::OP_WRITE,
                spi_slave_pkg::OP_READ,
                spi_slave_pkg::OP_QREAD: begin
                  op    <= spi_slave_pkg::spi_op_e'(rx_byte);
                  state <= ST_ADDR;
                end
                default: state <= ST_DISCARD;
              endcase
            end
          end
          ST_ADDR: begin
            if (rx_valid) begin
              addr <= rx_byte[spi_slave_pkg::ADDR_W-1:0];
              if (op == spi_slave_pkg::OP_WRITE) begin
                state <= ST_WRITE_DATA;
              end else begin
                // first read byte goes out right after the address
                state     <= ST_READ_DATA;
                load      <= 1'b1;
                quad_mode <= (op == spi_slave_pkg::OP_QREAD);
              end
            end
          end
          ST_WRITE_DATA: begin
            if (rx_valid) begin
              addr <= addr + 1'b1;
            end
          end
          ST_READ_DATA: begin
            // each finished byte moves on to the next register
            if (rx_valid) begin
              addr <= addr + 1'b1;
              load <= 1'b1;
            end
          end
          ST_DISCARD: begin
            // unknown opcode, wait for cs_n to rise
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // register access and transmit load
  // --------------------------------------------------------------------------

  // write strobe in the same cycle as rx_valid
  always_comb begin
    reg_req.we    = (state == ST_WRITE_DATA) && rx_valid;
    reg_req.addr  = addr;
    reg_req.wdata = rx_byte;
  end

  // rdata follows addr, already advanced when load is high
  always_comb begin
    tx_cmd.load = load;
    tx_cmd.quad = quad_mode;
    tx_cmd.data = rdata;
  end

endmodule

//--- rtl/spi_reg_bank.sv
module spi_reg_bank (
  input  logic                             sclk,
  input  logic                             arst_n,
  input  spi_slave_pkg::reg_req_t          reg_req,
  output logic [spi_slave_pkg::DATA_W-1:0] rdata
);

  logic [spi_slave_pkg::DATA_W-1:0] regs [spi_slave_pkg::REG_COUNT];

  // --------------------------------------------------------------------------
  // write port
  // --------------------------------------------------------------------------

  // all registers read back zero after reset
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < spi_slave_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_req.we) begin
      regs[reg_req.addr] <= reg_req.wdata;
    end
  end

  // --------------------------------------------------------------------------
  // read port
  // --------------------------------------------------------------------------

  // combinational, so the controller sees the new address at once
  assign rdata = regs[reg_req.addr];

endmodule

//--- rtl/spi_slave_top.sv
module spi_slave_top (
  input  logic                            sclk,
  input  logic                            arst_n,
  input  spi_slave_pkg::spi_mode_t        mode,
  input  logic                            spi_clk,
  input  logic                            cs_n,
  input  logic [spi_slave_pkg::LANES-1:0] mosi,
  output logic [spi_slave_pkg::LANES-1:0] miso,
  output logic [spi_slave_pkg::LANES-1:0] miso_oe
);

  spi_slave_pkg::spi_edges_t        edges;
  spi_slave_pkg::tx_cmd_t           tx_cmd;
  spi_slave_pkg::reg_req_t          reg_req;
  logic                             rx_valid;
  logic [spi_slave_pkg::DATA_W-1:0] rx_byte;
  logic [spi_slave_pkg::DATA_W-1:0] rdata;
  logic                             quad_mode;

  // pin sampling into the sclk domain
  spi_edge_sync spi_edge_sync_inst (
    .sclk    (sclk),
    .arst_n  (arst_n),
    .mode    (mode),
    .spi_clk (spi_clk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .edges   (edges)
  );

  spi_shift_reg spi_shift_reg_inst (
    .sclk      (sclk),
    .arst_n    (arst_n),
    .quad_mode (quad_mode),
    .edges     (edges),
    .tx_cmd    (tx_cmd),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .miso      (miso),
    .miso_oe   (miso_oe)
  );

  spi_slave_ctrl spi_slave_ctrl_inst (
    .sclk      (sclk),
    .arst_n    (arst_n),
    .edges     (edges),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rdata     (rdata),
    .tx_cmd    (tx_cmd),
    .reg_req   (reg_req),
    .quad_mode (quad_mode)
  );

  spi_reg_bank spi_reg_bank_inst (
    .sclk    (sclk),
    .arst_n  (arst_n),
    .reg_req (reg_req),
    .rdata   (rdata)
  );

endmodule

//--- sim/tb_spi_slave_tasks.svh
`ifndef TB_SPI_SLAVE_TASKS_SVH
`define TB_SPI_SLAVE_TASKS_SVH

  typedef logic [spi_slave_pkg::DATA_W-1:0] byte_q_t [$];

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first mismatch");
  endtask

  task automatic check_byte(input string name, input logic [spi_slave_pkg::DATA_W-1:0] got,
                            input logic [spi_slave_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_oe(input string name, input logic [spi_slave_pkg::LANES-1:0] got,
                          input logic [spi_slave_pkg::LANES-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // bit-banging master
  // --------------------------------------------------------------------------

  // returns 2 time units after a rising sclk edge
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge sclk);
    #2;
  endtask

  // mode and idle clock level change only with cs_n high
  task automatic open_frame(input spi_slave_pkg::spi_mode_t m);
    mode    = m;
    spi_clk = m.cpol;
    idle_cycles(HALF_PERIOD);
    cs_n = 1'b0;
    idle_cycles(HALF_PERIOD);
  endtask

  task automatic close_frame();
    idle_cycles(HALF_PERIOD);
    cs_n = 1'b1;
    idle_cycles(2 * HALF_PERIOD);
    check_oe("miso_oe", miso_oe, '0);
  endtask

  // one spi_clk period, miso seen at the master's sample edge
  task automatic clock_unit(input logic [spi_slave_pkg::LANES-1:0] dout,
                            input logic [spi_slave_pkg::LANES-1:0] oe_exp,
                            output logic [spi_slave_pkg::LANES-1:0] din);
    if (mode.cpha) begin
      spi_clk = ~spi_clk;
    end
    mosi = dout;
    idle_cycles(HALF_PERIOD);
    din = miso;
    check_oe("miso_oe", miso_oe, oe_exp);
    spi_clk = ~spi_clk;
    idle_cycles(HALF_PERIOD);
    if (!mode.cpha) begin
      spi_clk = ~spi_clk;
    end
  endtask

  // single lane, MSB first both ways
  task automatic xfer_byte(input logic [spi_slave_pkg::DATA_W-1:0] dout, input logic oe_on,
                           output logic [spi_slave_pkg::DATA_W-1:0] din);
    logic [spi_slave_pkg::LANES-1:0] lanes;
    for (int i = spi_slave_pkg::DATA_W - 1; i >= 0; i--) begin
      clock_unit({{(spi_slave_pkg::LANES-1){1'b0}}, dout[i]},
                 {{(spi_slave_pkg::LANES-1){1'b0}}, oe_on}, lanes);
      din[i] = lanes[0];
    end
  endtask

  // upper nibble first
  task automatic quad_byte(output logic [spi_slave_pkg::DATA_W-1:0] din);
    logic [spi_slave_pkg::LANES-1:0] hi;
    logic [spi_slave_pkg::LANES-1:0] lo;
    clock_unit('0, '1, hi);
    clock_unit('0, '1, lo);
    din = {hi, lo};
  endtask

  task automatic write_frame(input spi_slave_pkg::spi_mode_t m,
                             input logic [spi_slave_pkg::ADDR_W-1:0] addr, input byte_q_t data);
    logic [spi_slave_pkg::DATA_W-1:0] unused;
    logic [spi_slave_pkg::ADDR_W-1:0] a;
    open_frame(m);
    xfer_byte(spi_slave_pkg::OP_WRITE, 1'b0, unused);
    xfer_byte({4'h0, addr}, 1'b0, unused);
    a = addr;
    foreach (data[i]) begin
      xfer_byte(data[i], 1'b0, unused);
      model[a] = data[i];
      a++;
    end
    close_frame();
  endtask

  // every byte read is compared with the model, address wraps at 16
  task automatic read_frame(input spi_slave_pkg::spi_mode_t m, input logic quad,
                            input logic [spi_slave_pkg::ADDR_W-1:0] addr, input int count);
    logic [spi_slave_pkg::DATA_W-1:0] unused;
    logic [spi_slave_pkg::DATA_W-1:0] got;
    logic [spi_slave_pkg::ADDR_W-1:0] a;
    open_frame(m);
    xfer_byte(quad ? spi_slave_pkg::OP_QREAD : spi_slave_pkg::OP_READ, 1'b0, unused);
    xfer_byte({4'h0, addr}, 1'b0, unused);
    a = addr;
    repeat (count) begin
      if (quad) begin
        quad_byte(got);
      end else begin
        xfer_byte('0, 1'b1, got);
      end
      check_byte($sformatf("miso data of reg 0x%h", a), got, model[a]);
      a++;
    end
    close_frame();
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic test_reset_values();
    check_oe("miso_oe", miso_oe, '0);
    check_oe("miso", miso, '0);
    for (int a = 0; a < spi_slave_pkg::REG_COUNT; a++) begin
      read_frame('0, 1'b0, 4'(a), 1);
    end
  endtask

  task automatic test_all_modes();
    byte_q_t data;
    logic [spi_slave_pkg::ADDR_W-1:0] addr;
    for (int i = 0; i < 4; i++) begin
      addr = 4'($urandom);
      data.delete();
      data.push_back(8'($urandom));
      write_frame(spi_slave_pkg::spi_mode_t'(2'(i)), addr, data);
      read_frame(spi_slave_pkg::spi_mode_t'(2'(i)), 1'b0, addr, 1);
    end
  endtask

  // 20 bytes from 10 wrap past 15 and overwrite 10 to 13
  task automatic test_bursts();
    byte_q_t data;
    repeat (20) begin
      data.push_back(8'($urandom));
    end
    write_frame('0, 4'd10, data);
    read_frame('0, 1'b0, 4'd0, spi_slave_pkg::REG_COUNT);
  endtask

  task automatic test_quad_read();
    read_frame(spi_slave_pkg::spi_mode_t'(2'b00), 1'b1, 4'd0, spi_slave_pkg::REG_COUNT);
    read_frame(spi_slave_pkg::spi_mode_t'(2'b11), 1'b1, 4'd5, spi_slave_pkg::REG_COUNT);
  endtask

  task automatic test_unknown_opcode();
    logic [spi_slave_pkg::DATA_W-1:0] unused;
    open_frame('0);
    xfer_byte(8'h55, 1'b0, unused);
    repeat (4) begin
      xfer_byte(8'($urandom), 1'b0, unused);
    end
    close_frame();
    read_frame('0, 1'b0, 4'd0, spi_slave_pkg::REG_COUNT);
  endtask

  // cs_n rises after four data bits, so the register keeps its value
  task automatic test_aborted_byte();
    byte_q_t data;
    logic [spi_slave_pkg::DATA_W-1:0] unused;
    logic [spi_slave_pkg::LANES-1:0] lanes;
    logic [spi_slave_pkg::ADDR_W-1:0] addr;
    logic [spi_slave_pkg::DATA_W-1:0] partial;
    addr    = 4'($urandom);
    partial = ~model[addr];
    open_frame('0);
    xfer_byte(spi_slave_pkg::OP_WRITE, 1'b0, unused);
    xfer_byte({4'h0, addr}, 1'b0, unused);
    for (int i = spi_slave_pkg::DATA_W - 1; i >= 4; i--) begin
      clock_unit({{(spi_slave_pkg::LANES-1){1'b0}}, partial[i]}, '0, lanes);
    end
    close_frame();
    read_frame('0, 1'b0, addr, 1);
    data.push_back(8'($urandom));
    write_frame('0, addr, data);
    read_frame('0, 1'b0, addr, 1);
  endtask

`endif

//--- sim/tb_spi_slave.sv
module tb_spi_slave;

  // master timing in sclk cycles
  localparam int HALF_PERIOD    = 6;
  localparam int RESET_CYCLES   = 8;
  // about twice the summed length of all frames below
  localparam int TIMEOUT_CYCLES = 40000;

  logic                            sclk;
  logic                            arst_n;
  spi_slave_pkg::spi_mode_t        mode;
  logic                            spi_clk;
  logic                            cs_n;
  logic [spi_slave_pkg::LANES-1:0] mosi;
  logic [spi_slave_pkg::LANES-1:0] miso;
  logic [spi_slave_pkg::LANES-1:0] miso_oe;

  // expected register contents, updated by every write sent
  logic [spi_slave_pkg::DATA_W-1:0] model [spi_slave_pkg::REG_COUNT];
  int unsigned cycle_count;

  spi_slave_top spi_slave_top_inst (
    .sclk    (sclk),
    .arst_n  (arst_n),
    .mode    (mode),
    .spi_clk (spi_clk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso),
    .miso_oe (miso_oe)
  );

  `include "tb_spi_slave_tasks.svh"

  // --------------------------------------------------------------------------
  // clock and run limit
  // --------------------------------------------------------------------------

  initial begin
    sclk = 1'b0;
    forever #10 sclk = ~sclk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge sclk);
      cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d sclk cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $fatal(1, "run ended by the cycle limit");
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin
    void'($urandom(32'h2e67_fca9));
    arst_n  = 1'b0;
    mode    = '0;
    spi_clk = 1'b0;
    cs_n    = 1'b1;
    mosi    = '0;
    for (int i = 0; i < spi_slave_pkg::REG_COUNT; i++) begin
      model[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge sclk);
    #2;
    arst_n = 1'b1;
    idle_cycles(4);

    test_reset_values();
    test_all_modes();
    test_bursts();
    test_quad_read();
    test_unknown_opcode();
    test_aborted_byte();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- spi_slave.f
+incdir+sim
rtl/spi_slave_pkg.sv
rtl/spi_edge_sync.sv
rtl/spi_shift_reg.sv
rtl/spi_slave_ctrl.sv
rtl/spi_reg_bank.sv
rtl/spi_slave_top.sv
sim/tb_spi_slave.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary -Wno-fatal -j 0
TOP      := tb_spi_slave
FILELIST := spi_slave.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
